//--- common/iq_macros.svh
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// queue geometry
`define IQ_DEPTH 8
`define IQ_LOG 3

// tag and ROB index widths
`define PREG_W 6
`define ROB_LOG 5

// operand and opcode widths
`define IMM_W 12
`define ALU_TYPE_W 4

`endif

//--- common/iq_pkg.sv
`default_nettype none

package iq_pkg;

`include "iq_macros.svh"

    // physical register tag
    typedef logic [`PREG_W-1:0] preg_t;

    // ROB position, wrap flag on top
    typedef struct packed {
        logic                flag;
        logic [`ROB_LOG-1:0] idx;
    } rob_id_t;

    // ----------------------------------------------------------------------
    // operand 2 word, read as a tag or as an immediate per src2_is_reg
    // ----------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [`IMM_W-`PREG_W-1:0] pad;
            preg_t                     tag;
        } rg;
        logic [`IMM_W-1:0] imm;
    } op2_u;

    typedef struct packed {
        preg_t                  prs1;
        logic                   src1_is_reg;
        op2_u                   op2;
        logic                   src2_is_reg;
        preg_t                  prd;
        logic                   need_to_wb;
        logic [`ALU_TYPE_W-1:0] alu_type;
        rob_id_t                rob_id;
    } iq_payload_t;

    // dispatch request, ready bits are the operand state at rename
    typedef struct packed {
        logic        valid;
        iq_payload_t payload;
        logic        src1_ready;
        logic        src2_ready;
    } enq_req_t;

    typedef struct packed {
        logic  valid;
        logic  need_to_wb;
        preg_t prd;
    } wb_port_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
    } flush_req_t;

endpackage

`default_nettype wire

//--- issue_queue/iq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module iq_ctrl (
    input  wire                             enq_valid,
    input  iq_pkg::flush_req_t              flush,
    input  wire                             issue_ready,
    input  wire [`IQ_DEPTH-1:0]             entry_valid,
    input  iq_pkg::rob_id_t [`IQ_DEPTH-1:0] entry_rob_id,
    input  wire [`IQ_DEPTH-1:0]             oldest_ready_oh,
    output logic                            can_alloc,
    output logic                            issue_valid,
    output logic [`IQ_DEPTH-1:0]            write_oh,
    output logic [`IQ_DEPTH-1:0]            clear_oh,
    output logic [`IQ_DEPTH-1:0]            kill_mask
);

    logic [`IQ_LOG-1:0] free_idx;
    logic               any_free;
    logic               enq_fire;
    logic               issue_fire;

    // ----------------------------------------------------------------------
    // enqueue, lowest free slot wins
    // ----------------------------------------------------------------------
    always_comb begin
        free_idx = '0;
        any_free = 1'b0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = i[`IQ_LOG-1:0];
                any_free = 1'b1;
            end
        end
    end

    assign can_alloc = any_free;

    // strobe dropped when full or during a flush
    assign enq_fire = enq_valid & any_free & ~flush.valid;
    assign write_oh = enq_fire ? ({{(`IQ_DEPTH-1){1'b0}}, 1'b1} << free_idx) : '0;

    // ----------------------------------------------------------------------
    // issue handshake
    // ----------------------------------------------------------------------
    assign issue_valid = |oldest_ready_oh;
    assign issue_fire  = issue_valid & issue_ready;
    assign clear_oh    = issue_fire ? oldest_ready_oh : '0;

    // ----------------------------------------------------------------------
    // flush, kill everything younger than the flush point
    // ----------------------------------------------------------------------
    always_comb begin
        kill_mask = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (flush.valid && entry_valid[i]) begin
                if (entry_rob_id[i].flag == flush.rob_id.flag) begin
                    kill_mask[i] = entry_rob_id[i].idx > flush.rob_id.idx;
                end else begin
                    // ROB wrapped between flush point and entry
                    kill_mask[i] = entry_rob_id[i].idx < flush.rob_id.idx;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- issue_queue/iq_entry_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module iq_entry_array (
    input  wire                              clock,
    input  wire                              rst_n,
    input  iq_pkg::iq_payload_t              enq_payload,
    input  wire                              enq_src1_ready,
    input  wire                              enq_src2_ready,
    input  wire [`IQ_DEPTH-1:0]              write_oh,
    input  wire [`IQ_DEPTH-1:0]              clear_oh,
    input  wire [`IQ_DEPTH-1:0]              kill_mask,
    input  wire [`IQ_DEPTH-1:0]              wake_src1,
    input  wire [`IQ_DEPTH-1:0]              wake_src2,
    input  wire [`IQ_DEPTH-1:0]              issue_oh,
    output logic [`IQ_DEPTH-1:0]             entry_valid,
    output logic [`IQ_DEPTH-1:0]             entry_ready,
    output iq_pkg::rob_id_t [`IQ_DEPTH-1:0]  entry_rob_id,
    output iq_pkg::preg_t [`IQ_DEPTH-1:0]    src1_tags,
    output iq_pkg::preg_t [`IQ_DEPTH-1:0]    src2_tags,
    output logic [`IQ_DEPTH-1:0]             src1_wait,
    output logic [`IQ_DEPTH-1:0]             src2_wait,
    output iq_pkg::iq_payload_t              issue_payload
);

    iq_pkg::iq_payload_t payload [`IQ_DEPTH];

    logic [`IQ_DEPTH-1:0] valid_q;
    logic [`IQ_DEPTH-1:0] src1_rdy_q;
    logic [`IQ_DEPTH-1:0] src2_rdy_q;

    // ----------------------------------------------------------------------
    // per-entry control state
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q    <= '0;
            src1_rdy_q <= '0;
            src2_rdy_q <= '0;
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (write_oh[i]) begin
                    // immediate or non-reg source counts as ready
                    valid_q[i]    <= 1'b1;
                    src1_rdy_q[i] <= enq_src1_ready | ~enq_payload.src1_is_reg;
                    src2_rdy_q[i] <= enq_src2_ready | ~enq_payload.src2_is_reg;
                end else if (clear_oh[i] || kill_mask[i]) begin
                    valid_q[i] <= 1'b0;
                end else begin
                    src1_rdy_q[i] <= src1_rdy_q[i] | wake_src1[i];
                    src2_rdy_q[i] <= src2_rdy_q[i] | wake_src2[i];
                end
            end
        end
    end

    // payload only written on enqueue
    always_ff @(posedge clock) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (write_oh[i]) begin
                payload[i] <= enq_payload;
            end
        end
    end

    // ----------------------------------------------------------------------
    // status out to ctrl, wakeup and age matrix
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            entry_rob_id[i] = payload[i].rob_id;
            src1_tags[i]    = payload[i].prs1;
            src2_tags[i]    = payload[i].op2.rg.tag;
            src1_wait[i]    = valid_q[i] & payload[i].src1_is_reg & ~src1_rdy_q[i];
            src2_wait[i]    = valid_q[i] & payload[i].src2_is_reg & ~src2_rdy_q[i];
        end
    end

    assign entry_valid = valid_q;
    assign entry_ready = valid_q & src1_rdy_q & src2_rdy_q;

    // one-hot and-or mux
    always_comb begin
        issue_payload = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            issue_payload = issue_payload | (payload[i] & {$bits(issue_payload){issue_oh[i]}});
        end
    end

endmodule

`default_nettype wire

//--- issue_queue/iq_wakeup.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module iq_wakeup (
    input  iq_pkg::wb_port_t              wb0,
    input  iq_pkg::wb_port_t              wb1,
    input  iq_pkg::preg_t [`IQ_DEPTH-1:0] src1_tags,
    input  iq_pkg::preg_t [`IQ_DEPTH-1:0] src2_tags,
    input  wire [`IQ_DEPTH-1:0]           src1_wait,
    input  wire [`IQ_DEPTH-1:0]           src2_wait,
    output logic [`IQ_DEPTH-1:0]          wake_src1,
    output logic [`IQ_DEPTH-1:0]          wake_src2
);

    // one writeback port against one source tag
    function automatic logic port_hit(iq_pkg::wb_port_t wb, iq_pkg::preg_t tag);
        port_hit = wb.valid & wb.need_to_wb & (wb.prd == tag);
    endfunction

    // ----------------------------------------------------------------------
    // tag compare, only sources still waiting on a register
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            wake_src1[i] = src1_wait[i]
                & (port_hit(wb0, src1_tags[i]) | port_hit(wb1, src1_tags[i]));
            wake_src2[i] = src2_wait[i]
                & (port_hit(wb0, src2_tags[i]) | port_hit(wb1, src2_tags[i]));
        end
    end

endmodule

`default_nettype wire

//--- issue_queue/iq_age_matrix.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module iq_age_matrix (
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire [`IQ_DEPTH-1:0]  write_oh,
    input  wire [`IQ_DEPTH-1:0]  entry_valid,
    input  wire [`IQ_DEPTH-1:0]  entry_ready,
    output logic [`IQ_DEPTH-1:0] oldest_ready_oh
);

    // older_q[i][j] set means entry j is older than entry i
    logic [`IQ_DEPTH-1:0] older_q [`IQ_DEPTH];

    // ----------------------------------------------------------------------
    // row update on enqueue
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (write_oh[i]) begin
                    // everything already in the queue is older
                    older_q[i] <= entry_valid;
                end else begin
                    // new entry is younger than all others, drop stale column
                    older_q[i] <= older_q[i] & ~write_oh;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // oldest ready select
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            oldest_ready_oh[i] = entry_ready[i] & ~|(older_q[i] & entry_ready);
        end
    end

endmodule

`default_nettype wire

//--- issue_queue/int_issue_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module int_issue_queue (
    input  wire                 clock,
    input  wire                 rst_n,
    input  iq_pkg::enq_req_t    enq,
    output logic                can_alloc,
    input  iq_pkg::wb_port_t    wb0,
    input  iq_pkg::wb_port_t    wb1,
    input  iq_pkg::flush_req_t  flush,
    output logic                issue_valid,
    input  wire                 issue_ready,
    output iq_pkg::iq_payload_t issue_payload
);

    // ----------------------------------------------------------------------
    // per-entry masks between the blocks
    // ----------------------------------------------------------------------
    logic [`IQ_DEPTH-1:0] write_oh;
    logic [`IQ_DEPTH-1:0] clear_oh;
    logic [`IQ_DEPTH-1:0] kill_mask;
    logic [`IQ_DEPTH-1:0] entry_valid;
    logic [`IQ_DEPTH-1:0] entry_ready;
    logic [`IQ_DEPTH-1:0] oldest_ready_oh;
    logic [`IQ_DEPTH-1:0] wake_src1;
    logic [`IQ_DEPTH-1:0] wake_src2;
    logic [`IQ_DEPTH-1:0] src1_wait;
    logic [`IQ_DEPTH-1:0] src2_wait;

    iq_pkg::rob_id_t [`IQ_DEPTH-1:0] entry_rob_id;
    iq_pkg::preg_t   [`IQ_DEPTH-1:0] src1_tags;
    iq_pkg::preg_t   [`IQ_DEPTH-1:0] src2_tags;

    iq_ctrl iq_ctrl_inst (
        .enq_valid      (enq.valid),
        .flush          (flush),
        .issue_ready    (issue_ready),
        .entry_valid    (entry_valid),
        .entry_rob_id   (entry_rob_id),
        .oldest_ready_oh(oldest_ready_oh),
        .can_alloc      (can_alloc),
        .issue_valid    (issue_valid),
        .write_oh       (write_oh),
        .clear_oh       (clear_oh),
        .kill_mask      (kill_mask)
    );

    iq_entry_array iq_entry_array_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .enq_payload   (enq.payload),
        .enq_src1_ready(enq.src1_ready),
        .enq_src2_ready(enq.src2_ready),
        .write_oh      (write_oh),
        .clear_oh      (clear_oh),
        .kill_mask     (kill_mask),
        .wake_src1     (wake_src1),
        .wake_src2     (wake_src2),
        .issue_oh      (oldest_ready_oh),
        .entry_valid   (entry_valid),
        .entry_ready   (entry_ready),
        .entry_rob_id  (entry_rob_id),
        .src1_tags     (src1_tags),
        .src2_tags     (src2_tags),
        .src1_wait     (src1_wait),
        .src2_wait     (src2_wait),
        .issue_payload (issue_payload)
    );

    iq_wakeup iq_wakeup_inst (
        .wb0      (wb0),
        .wb1      (wb1),
        .src1_tags(src1_tags),
        .src2_tags(src2_tags),
        .src1_wait(src1_wait),
        .src2_wait(src2_wait),
        .wake_src1(wake_src1),
        .wake_src2(wake_src2)
    );

    iq_age_matrix iq_age_matrix_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .write_oh       (write_oh),
        .entry_valid    (entry_valid),
        .entry_ready    (entry_ready),
        .oldest_ready_oh(oldest_ready_oh)
    );

endmodule

`default_nettype wire

//--- testbench/iq_checker.sv
`timescale 1ns/1ns
`default_nettype none

module iq_checker (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 can_alloc,
    input  wire                 issue_valid,
    input  wire                 issue_ready,
    input  iq_pkg::iq_payload_t issue_payload,
    input  wire                 exp_valid,
    input  iq_pkg::preg_t       exp_prd,
    input  iq_pkg::rob_id_t     exp_rob_id,
    input  iq_pkg::op2_u        exp_op2,
    input  wire                 exp_status_en,
    input  wire [1:0]           exp_status,
    input  wire                 done,
    output int                  value_errors,
    output int                  order_errors,
    output int                  pending
);

    typedef struct packed {
        iq_pkg::preg_t   prd;
        iq_pkg::rob_id_t rob_id;
        iq_pkg::op2_u    op2;
    } exp_rec_t;

    exp_rec_t exp_q [$];
    logic     end_checked;

    task automatic compare_value(input string name, input logic [11:0] got,
                                 input logic [11:0] want);
        if (got !== want) begin
            $display("ERR %s: got %h, expected %h", name, got, want);
            value_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // sampled at the rising edge, inputs were set at the falling edge
    // ----------------------------------------------------------------------
    always @(posedge clock) begin
        exp_rec_t rec;
        if (!rst_n) begin
            value_errors = 0;
            order_errors = 0;
            pending      = 0;
            end_checked  = 1'b0;
            exp_q.delete();
        end else begin
            // record of this cycle queued before a possible fire
            if (exp_valid) begin
                exp_q.push_back('{prd: exp_prd, rob_id: exp_rob_id, op2: exp_op2});
            end
            if (exp_status_en) begin
                compare_value("can_alloc", {11'b0, can_alloc}, {11'b0, exp_status[1]});
                compare_value("issue_valid", {11'b0, issue_valid}, {11'b0, exp_status[0]});
            end
            if (issue_valid && issue_ready) begin
                if (exp_q.size() == 0) begin
                    $display("extra issue: prd %h rob_id %h fired with no issue expected",
                             issue_payload.prd, issue_payload.rob_id);
                    order_errors++;
                end else begin
                    rec = exp_q.pop_front();
                    compare_value("issue_payload.prd", {6'b0, issue_payload.prd},
                                  {6'b0, rec.prd});
                    compare_value("issue_payload.rob_id", {6'b0, issue_payload.rob_id},
                                  {6'b0, rec.rob_id});
                    compare_value("issue_payload.op2", issue_payload.op2, rec.op2);
                end
            end
            if (done && !end_checked) begin
                end_checked = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("missing issue: %0d expected issues never fired", exp_q.size());
                    order_errors = order_errors + exp_q.size();
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_int_issue_queue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_int_issue_queue;

    localparam int    COLS           = 19;
    localparam int    MAX_LINES      = 256;
    localparam int    RESET_CYCLES   = 10;
    localparam int    TIMEOUT_MARGIN = 50;
    localparam int    DRAIN_LIMIT    = 20;
    localparam string TRACE_PATH     = "testbench/iq_trace.txt";

    // COLS tokens per trace line in one flat store
    logic [15:0] trace_mem [0:MAX_LINES*COLS-1];

    logic                clock;
    logic                rst_n;
    iq_pkg::enq_req_t    enq;
    iq_pkg::wb_port_t    wb0;
    iq_pkg::wb_port_t    wb1;
    iq_pkg::flush_req_t  flush;
    logic                issue_ready;
    logic                can_alloc;
    logic                issue_valid;
    iq_pkg::iq_payload_t issue_payload;

    // expected side for the checker
    logic            exp_valid;
    iq_pkg::preg_t   exp_prd;
    iq_pkg::rob_id_t exp_rob_id;
    iq_pkg::op2_u    exp_op2;
    logic            exp_status_en;
    logic [1:0]      exp_status;
    logic            done;
    int              value_errors;
    int              order_errors;
    int              pending;

    int line_count;
    int drain_cycles;
    int cycle_count = 0;
    int cycle_limit = 0;

    int_issue_queue int_issue_queue_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .enq          (enq),
        .can_alloc    (can_alloc),
        .wb0          (wb0),
        .wb1          (wb1),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_payload(issue_payload)
    );

    iq_checker iq_checker_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .can_alloc    (can_alloc),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_payload(issue_payload),
        .exp_valid    (exp_valid),
        .exp_prd      (exp_prd),
        .exp_rob_id   (exp_rob_id),
        .exp_op2      (exp_op2),
        .exp_status_en(exp_status_en),
        .exp_status   (exp_status),
        .done         (done),
        .value_errors (value_errors),
        .order_errors (order_errors),
        .pending      (pending)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic clear_inputs();
        enq           = '0;
        wb0           = '0;
        wb1           = '0;
        flush         = '0;
        issue_ready   = 1'b0;
        exp_valid     = 1'b0;
        exp_prd       = '0;
        exp_rob_id    = '0;
        exp_op2       = '0;
        exp_status_en = 1'b0;
        exp_status    = '0;
    endtask

    // ----------------------------------------------------------------------
    // one trace line onto the DUT and checker inputs
    // ----------------------------------------------------------------------
    task automatic apply_line(input int line);
        logic [15:0] f [COLS];
        for (int c = 0; c < COLS; c++) begin
            f[c] = trace_mem[line * COLS + c];
        end
        enq.valid               = f[0][0];
        enq.payload.prs1        = f[1][5:0];
        enq.payload.src1_is_reg = f[2][0];
        enq.payload.op2.imm     = f[3][11:0];
        enq.payload.src2_is_reg = f[4][0];
        enq.payload.prd         = f[5][5:0];
        enq.payload.need_to_wb  = f[6][0];
        enq.payload.alu_type    = f[7][3:0];
        enq.payload.rob_id      = f[8][5:0];
        enq.src1_ready          = f[9][1];
        enq.src2_ready          = f[9][0];
        wb0                     = f[10][7:0];
        wb1                     = f[11][7:0];
        flush                   = f[12][6:0];
        issue_ready             = f[13][0];
        // status column f means no check this cycle
        exp_status_en           = (f[14] != 16'hf);
        exp_status              = f[14][1:0];
        exp_valid               = f[15][0];
        exp_prd                 = f[16][5:0];
        exp_rob_id              = f[17][5:0];
        exp_op2.imm             = f[18][11:0];
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        done  = 1'b0;
        clear_inputs();
        $readmemh(TRACE_PATH, trace_mem);
        line_count = 0;
        while (line_count < MAX_LINES && trace_mem[line_count * COLS] != 16'he) begin
            line_count++;
        end
        cycle_limit = RESET_CYCLES + line_count + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        for (int n = 0; n < line_count; n++) begin
            apply_line(n);
            @(negedge clock);
        end
        clear_inputs();
        issue_ready = 1'b1;

        // drain whatever the trace still expects
        drain_cycles = 0;
        while (pending != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clock);
            drain_cycles++;
        end
        done = 1'b1;
        @(posedge clock);
        #1;
        $display("errors: %0d value mismatches, %0d missing or extra issues",
                 value_errors, order_errors);
        if (value_errors == 0 && order_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit != 0 && cycle_count >= cycle_limit);
        $display("timeout: run stopped after %0d cycles, %0d expected issues never fired",
                 cycle_count, pending);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/iq_trace.txt
// one line per cycle, hex: ev prs1 s1r op2 s2r prd nwb alu rob rdy(s1,s2) wb0 wb1 flush ir
// then st {can_alloc,issue_valid} (f = unchecked) and expected issue xv xprd xrob xop2
// reset state, then ready instructions issue oldest first
0 00 0 000 0 00 0 0 00 0 00 00 00 1 2 0 00 00 000
1 01 1 002 1 10 1 1 00 3 00 00 00 0 2 0 00 00 000
1 03 0 7ff 0 11 1 2 01 0 00 00 00 0 3 0 00 00 000
1 04 1 025 1 12 1 3 02 3 00 00 00 1 3 1 10 00 002
0 00 0 000 0 00 0 0 00 0 00 00 00 1 3 1 11 01 7ff
0 00 0 000 0 00 0 0 00 0 00 00 00 1 3 1 12 02 025
0 00 0 000 0 00 0 0 00 0 00 00 00 1 2 0 00 00 000
// wakeup through both ports, need_to_wb low ignored
1 20 1 021 1 13 1 4 03 0 00 00 00 1 2 0 00 00 000
1 22 1 abc 0 14 1 5 04 0 00 00 00 1 2 0 00 00 000
0 00 0 000 0 00 0 0 00 0 a2 00 00 1 2 0 00 00 000
0 00 0 000 0 00 0 0 00 0 e2 e0 00 1 2 0 00 00 000
0 00 0 000 0 00 0 0 00 0 00 e1 00 1 3 1 14 04 abc
0 00 0 000 0 00 0 0 00 0 00 00 00 1 3 1 13 03 021
0 00 0 000 0 00 0 0 00 0 00 00 00 1 2 0 00 00 000
// fill all eight entries under back-pressure, rob ids cross the wrap
1 30 1 005 1 20 1 6 1c 1 00 00 00 0 2 0 00 00 000
1 31 1 123 0 21 1 7 1d 2 00 00 00 0 2 0 00 00 000
1 00 0 fff 0 22 1 8 1e 0 00 00 00 0 3 0 00 00 000
1 00 0 001 0 23 1 9 1f 0 00 00 00 0 f 0 00 00 000
1 00 0 002 0 24 1 a 20 0 00 00 00 0 f 0 00 00 000
1 00 0 003 0 25 1 b 21 0 00 00 00 0 f 0 00 00 000
1 00 0 004 0 26 1 c 22 0 00 00 00 0 f 0 00 00 000
1 00 0 005 0 27 1 d 23 0 00 00 00 0 3 0 00 00 000
// full, strobe dropped, oldest entry woken last still goes first
1 3f 0 0ee 0 3f 1 e 3f 0 f0 00 00 0 1 0 00 00 000
0 00 0 000 0 00 0 0 00 0 00 00 00 1 1 1 20 1c 005
0 00 0 000 0 00 0 0 00 0 00 00 00 0 3 0 00 00 000
// flush at 1e kills 1f and flag-set 20..23, strobe in flush cycle dropped
1 3e 0 0dd 0 3e 1 f 1f 0 00 00 5e 1 3 1 21 1d 123
0 00 0 000 0 00 0 0 00 0 00 00 00 1 3 1 22 1e fff
0 00 0 000 0 00 0 0 00 0 00 00 00 1 2 0 00 00 000
0 00 0 000 0 00 0 0 00 0 00 00 00 1 2 0 00 00 000
// end of trace
e

//--- build.f
+incdir+common
common/iq_pkg.sv
issue_queue/iq_ctrl.sv
issue_queue/iq_entry_array.sv
issue_queue/iq_wakeup.sv
issue_queue/iq_age_matrix.sv
issue_queue/int_issue_queue.sv
testbench/iq_checker.sv
testbench/tb_int_issue_queue.sv

//--- Makefile
# Verilator build and run of the issue queue testbench

LOG = sim.log

sim:
	verilator --binary --timing --timescale 1ns/1ns -f build.f --top-module tb_int_issue_queue -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
